//--- dcm_ptc_pkg.sv
// ==========================================================
// shared sizes and entry word fields of the page table
// controller; the entry word layout is fixed at 39 bits
// ==========================================================
package dcm_ptc_pkg;

  // ==========================================================
  // page and request sizes
  // ==========================================================

  // page index width inside one way
  localparam int page_addr_w = 5;

  // request id width, one slot per thread and id
  localparam int rid_w = 4;
  localparam int buf_depth = 2 ** (rid_w + 1);

  localparam int vaddr_w = 32;

  // ==========================================================
  // entry word
  // ==========================================================

  localparam int pte_w = 39;

  // virtual page number field, address bits 31..11
  localparam int vpn_lsb = 11;
  localparam int vpn_w = 21;

  // state codes, bits 9..8
  localparam logic [1:0] pte_state_pend = 2'b01;
  localparam logic [1:0] pte_state_done = 2'b10;

  // low flag nibble
  localparam logic [3:0] pte_flags_done = 4'b1110;
  localparam logic [3:0] pte_flags_pend = 4'b0000;

  // ==========================================================
  // clear sweep
  // ==========================================================

  // top bit set means the sweep is over
  localparam int sweep_cnt_w = page_addr_w + 3;

endpackage

//--- dcm_ptc_if.sv
// ==========================================================
// internal links of the page table controller; both are
// plain wires with no handshake of their own
// ==========================================================
`timescale 1ns/1ps

// held request, start or end
interface ptc_req_if
  import dcm_ptc_pkg::*;
();
  logic                   stb;
  logic                   last;
  logic                   tid;
  logic                   wid;
  logic                   tag;
  logic [page_addr_w-1:0] page;
  logic [vaddr_w-1:0]     v_addr;

  modport src (output stb, last, tid, wid, tag, page, v_addr);
  modport dst (input stb, last, tid, wid, tag, page, v_addr);
endinterface

// one page table write, also used for the flag table
interface ptc_pte_if
  import dcm_ptc_pkg::*;
();
  logic                   clr;
  logic                   stb;
  logic                   tid;
  logic                   eor;
  logic                   wid;
  logic [page_addr_w-1:0] page;
  logic [pte_w-1:0]       data;

  modport src (output clr, stb, tid, eor, wid, page, data);
  modport dst (input clr, stb, tid, eor, wid, page, data);
endinterface

//--- ptc_req_stage.sv
// ==========================================================
// one-deep holding stage for request start and end strobes
// a held request stays while ack_stb is high
// req_ack is combinational on the live strobes
// ==========================================================
`timescale 1ns/1ps

module ptc_req_stage
  import dcm_ptc_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   req_stb,
  input  logic                   req_end,
  input  logic                   req_tid,
  input  logic                   req_wid,
  input  logic                   req_tag,
  input  logic [page_addr_w-1:0] req_page,
  input  logic [vaddr_w-1:0]     req_v_addr,
  input  logic                   ack_stb,
  output logic                   req_ack,
  output logic                   req_rdy,
  ptc_req_if.src                 held
);

  logic capture;
  logic release_req;

  // take a new request only of a kind not already held
  assign capture = (req_stb && !held.stb) || (req_end && !held.last);

  // an ack from memory wins the entry generator, so keep waiting
  assign release_req = (held.stb || held.last) && !ack_stb;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      held.stb  <= 1'b0;
      held.last <= 1'b0;
    end
    else if (capture)
    begin
      held.stb  <= req_stb;
      held.last <= req_end;
    end
    else if (release_req)
    begin
      held.stb  <= 1'b0;
      held.last <= 1'b0;
    end
  end

  // request fields
  always_ff @(posedge clk)
  begin
    if (capture)
    begin
      held.tid    <= req_tid;
      held.wid    <= req_wid;
      held.tag    <= req_tag;
      held.page   <= req_page;
      held.v_addr <= req_v_addr;
    end
  end

  assign req_ack = (held.stb && req_stb) || (held.last && req_end);
  assign req_rdy = !(held.stb || held.last);

endmodule

//--- ptc_req_buffer.sv
// ==========================================================
// started requests, one slot per thread and request id
// a new start overwrites the slot, no occupancy tracking
// ==========================================================
`timescale 1ns/1ps

module ptc_req_buffer
  import dcm_ptc_pkg::*;
(
  input  logic                   clk,
  input  logic                   req_stb,
  input  logic                   req_tid,
  input  logic [rid_w-1:0]       req_rid,
  input  logic                   req_wid,
  input  logic                   req_tag,
  input  logic [page_addr_w-1:0] req_page,
  input  logic [vaddr_w-1:0]     req_v_addr,
  input  logic                   ack_tid,
  input  logic [rid_w-1:0]       ack_rid,
  output logic [page_addr_w-1:0] rd_page,
  output logic                   rd_wid,
  output logic                   rd_tag,
  output logic [vaddr_w-1:0]     rd_v_addr
);

  logic [page_addr_w-1:0] mem_page   [buf_depth];
  logic                   mem_wid    [buf_depth];
  logic                   mem_tag    [buf_depth];
  logic [vaddr_w-1:0]     mem_v_addr [buf_depth];

  logic [rid_w:0] wr_idx;
  logic [rid_w:0] rd_idx;

  // thread id is the top index bit
  assign wr_idx = {req_tid, req_rid};
  assign rd_idx = {ack_tid, ack_rid};

  always_ff @(posedge clk)
  begin
    if (req_stb)
    begin
      mem_page[wr_idx]   <= req_page;
      mem_wid[wr_idx]    <= req_wid;
      mem_tag[wr_idx]    <= req_tag;
      mem_v_addr[wr_idx] <= req_v_addr;
    end
  end

  // asynchronous read for the ack cycle
  assign rd_page   = mem_page[rd_idx];
  assign rd_wid    = mem_wid[rd_idx];
  assign rd_tag    = mem_tag[rd_idx];
  assign rd_v_addr = mem_v_addr[rd_idx];

endmodule

//--- ptc_entry_gen.sv
// ==========================================================
// clear sweep after reset, then one entry per cycle chosen
// as ack, held start, held end in that order
// requests and acks are ignored while rdy is low
// ==========================================================
`timescale 1ns/1ps

module ptc_entry_gen
  import dcm_ptc_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   ack_stb,
  input  logic                   ack_tid,
  input  logic [page_addr_w-1:0] rd_page,
  input  logic                   rd_wid,
  input  logic                   rd_tag,
  input  logic [vaddr_w-1:0]     rd_v_addr,
  ptc_req_if.dst                 held,
  ptc_pte_if.src                 pte,
  output logic                   rdy
);

  logic [sweep_cnt_w-1:0] sweep_cnt;

  logic                   nxt_clr;
  logic                   nxt_stb;
  logic                   nxt_tid;
  logic                   nxt_eor;
  logic                   nxt_wid;
  logic [page_addr_w-1:0] nxt_page;
  logic [pte_w-1:0]       nxt_data;

  // pending or completed entry word
  function automatic logic [pte_w-1:0] make_pte(
    input logic               done,
    input logic               tag,
    input logic [vaddr_w-1:0] va
  );
    logic [vpn_w-1:0] vpn;
    vpn = done ? va[vpn_lsb +: vpn_w] : '0;
    return {
      {(pte_w - vpn_lsb - vpn_w){1'b0}},
      vpn,
      done,
      done ? pte_state_done : pte_state_pend,
      tag,
      1'b0,
      {2{va[vaddr_w-1]}},
      done ? pte_flags_done : pte_flags_pend
    };
  endfunction

  // ==========================================================
  // decision
  // ==========================================================

  assign rdy = sweep_cnt[sweep_cnt_w-1];

  always_comb
  begin
    nxt_clr  = 1'b0;
    nxt_stb  = 1'b0;
    nxt_tid  = 1'b0;
    nxt_eor  = 1'b0;
    nxt_wid  = 1'b0;
    nxt_page = '0;
    nxt_data = '0;
    if (!rdy)
    begin
      // counter order, tid on top then wid then page
      nxt_clr  = 1'b1;
      nxt_stb  = 1'b1;
      nxt_tid  = sweep_cnt[page_addr_w+1];
      nxt_wid  = sweep_cnt[page_addr_w];
      nxt_page = sweep_cnt[page_addr_w-1:0];
    end
    else if (ack_stb)
    begin
      // memory answered, complete the buffered slot
      nxt_stb  = 1'b1;
      nxt_tid  = ack_tid;
      nxt_eor  = 1'b1;
      nxt_wid  = rd_wid;
      nxt_page = rd_page;
      nxt_data = make_pte(1'b1, rd_tag, rd_v_addr);
    end
    else if (held.stb)
    begin
      nxt_stb  = 1'b1;
      nxt_tid  = held.tid;
      nxt_wid  = held.wid;
      nxt_page = held.page;
      nxt_data = make_pte(1'b0, held.tag, held.v_addr);
    end
    else if (held.last)
    begin
      nxt_stb  = 1'b1;
      nxt_tid  = held.tid;
      nxt_wid  = held.wid;
      nxt_page = held.page;
      nxt_data = make_pte(1'b1, held.tag, held.v_addr);
    end
  end

  // ==========================================================
  // registers
  // ==========================================================

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      sweep_cnt <= '0;
      pte.clr   <= 1'b0;
      pte.stb   <= 1'b0;
      pte.eor   <= 1'b0;
    end
    else
    begin
      // saturates once the top bit sets
      if (!rdy)
        sweep_cnt <= sweep_cnt + sweep_cnt_w'(1);
      pte.clr <= nxt_clr;
      pte.stb <= nxt_stb;
      pte.eor <= nxt_eor;
    end
  end

  always_ff @(posedge clk)
  begin
    pte.tid  <= nxt_tid;
    pte.wid  <= nxt_wid;
    pte.page <= nxt_page;
    pte.data <= nxt_data;
  end

endmodule

//--- ptc_out_pipe.sv
// ==========================================================
// two cycle delay of the write record, matches the table
// read latency; fans out to page table and flag table
// ==========================================================
`timescale 1ns/1ps

module ptc_out_pipe
  import dcm_ptc_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  ptc_pte_if.dst                 pte,
  output logic                   ptw_stb,
  output logic                   ptw_tid,
  output logic                   ptw_eor,
  output logic                   ptw_wid,
  output logic [page_addr_w-1:0] ptw_page,
  output logic [pte_w-1:0]       ptw_data,
  output logic                   pwf_clr,
  output logic                   pwf_wen,
  output logic                   pwf_tid,
  output logic                   pwf_wid,
  output logic [page_addr_w-1:0] pwf_page
);

  // index 0 is the first stage, index 1 the output stage
  logic [1:0]                  dly_clr;
  logic [1:0]                  dly_stb;
  logic [1:0]                  dly_eor;
  logic [1:0]                  dly_tid;
  logic [1:0]                  dly_wid;
  logic [1:0][page_addr_w-1:0] dly_page;
  logic [1:0][pte_w-1:0]       dly_data;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      dly_clr <= '0;
      dly_stb <= '0;
      dly_eor <= '0;
    end
    else
    begin
      dly_clr <= {dly_clr[0], pte.clr};
      dly_stb <= {dly_stb[0], pte.stb};
      dly_eor <= {dly_eor[0], pte.eor};
    end
  end

  always_ff @(posedge clk)
  begin
    dly_tid  <= {dly_tid[0], pte.tid};
    dly_wid  <= {dly_wid[0], pte.wid};
    dly_page <= {dly_page[0], pte.page};
    dly_data <= {dly_data[0], pte.data};
  end

  // page table port
  assign ptw_stb  = dly_stb[1];
  assign ptw_tid  = dly_tid[1];
  assign ptw_eor  = dly_eor[1];
  assign ptw_wid  = dly_wid[1];
  assign ptw_page = dly_page[1];
  assign ptw_data = dly_data[1];

  // write flag port, written along with every entry
  assign pwf_clr  = dly_clr[1];
  assign pwf_wen  = dly_stb[1];
  assign pwf_tid  = dly_tid[1];
  assign pwf_wid  = dly_wid[1];
  assign pwf_page = dly_page[1];

endmodule

//--- dcm_ptc.sv
// ==========================================================
// page table controller of the data cache miss unit
// ptw_stb follows ack_stb by 3 cycles, a request by 4
// requests before rdy are dropped
// ==========================================================
`timescale 1ns/1ps

module dcm_ptc
  import dcm_ptc_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  output logic                   rdy,
  input  logic                   req_stb,
  input  logic                   req_end,
  output logic                   req_ack,
  input  logic [rid_w-1:0]       req_rid,
  input  logic                   req_tid,
  input  logic                   req_wid,
  input  logic                   req_tag,
  input  logic [page_addr_w-1:0] req_page,
  input  logic [vaddr_w-1:0]     req_v_addr,
  output logic                   req_rdy,
  input  logic                   ack_stb,
  input  logic [rid_w-1:0]       ack_rid,
  input  logic                   ack_tid,
  output logic                   ptw_stb,
  output logic                   ptw_tid,
  output logic                   ptw_eor,
  output logic                   ptw_wid,
  output logic [page_addr_w-1:0] ptw_page,
  output logic [pte_w-1:0]       ptw_data,
  output logic                   pwf_clr,
  output logic                   pwf_wen,
  output logic                   pwf_tid,
  output logic                   pwf_wid,
  output logic [page_addr_w-1:0] pwf_page
);

  logic [page_addr_w-1:0] rd_page;
  logic                   rd_wid;
  logic                   rd_tag;
  logic [vaddr_w-1:0]     rd_v_addr;

  ptc_req_if held_if ();
  ptc_pte_if pte_if ();

  ptc_req_stage u_req_stage (
    .clk(clk), .rst(rst),
    .req_stb(req_stb), .req_end(req_end),
    .req_tid(req_tid), .req_wid(req_wid), .req_tag(req_tag),
    .req_page(req_page), .req_v_addr(req_v_addr),
    .ack_stb(ack_stb), .req_ack(req_ack), .req_rdy(req_rdy),
    .held(held_if.src)
  );

  ptc_req_buffer u_req_buffer (
    .clk(clk), .req_stb(req_stb), .req_tid(req_tid), .req_rid(req_rid),
    .req_wid(req_wid), .req_tag(req_tag),
    .req_page(req_page), .req_v_addr(req_v_addr),
    .ack_tid(ack_tid), .ack_rid(ack_rid),
    .rd_page(rd_page), .rd_wid(rd_wid), .rd_tag(rd_tag), .rd_v_addr(rd_v_addr)
  );

  ptc_entry_gen u_entry_gen (
    .clk(clk), .rst(rst), .ack_stb(ack_stb), .ack_tid(ack_tid),
    .rd_page(rd_page), .rd_wid(rd_wid), .rd_tag(rd_tag), .rd_v_addr(rd_v_addr),
    .held(held_if.dst), .pte(pte_if.src), .rdy(rdy)
  );

  ptc_out_pipe u_out_pipe (
    .clk(clk), .rst(rst), .pte(pte_if.dst),
    .ptw_stb(ptw_stb), .ptw_tid(ptw_tid), .ptw_eor(ptw_eor), .ptw_wid(ptw_wid),
    .ptw_page(ptw_page), .ptw_data(ptw_data),
    .pwf_clr(pwf_clr), .pwf_wen(pwf_wen), .pwf_tid(pwf_tid), .pwf_wid(pwf_wid),
    .pwf_page(pwf_page)
  );

endmodule

//--- dcm_ptc_props.sv
// ==========================================================
// port level properties of the page table controller
// all checks are off while rst is high
// ==========================================================
`timescale 1ns/1ps

module dcm_ptc_props
  import dcm_ptc_pkg::*;
(
  input logic             clk,
  input logic             rst,
  input logic             rdy,
  input logic             req_stb,
  input logic             req_end,
  input logic             req_ack,
  input logic             ptw_stb,
  input logic             ptw_eor,
  input logic [pte_w-1:0] ptw_data,
  input logic             pwf_clr,
  input logic             pwf_wen
);

  // flag table is written with every entry
  a_wen_is_stb: assert property (@(posedge clk) disable iff (rst) pwf_wen == ptw_stb)
    else $error("pwf_wen differs from ptw_stb");

  // clear writes carry an empty word
  a_clr_clean: assert property (@(posedge clk) disable iff (rst)
    pwf_clr |-> (!ptw_eor && ptw_data == '0))
    else $error("clear write with eor or data set");

  a_ack_has_req: assert property (@(posedge clk) disable iff (rst)
    req_ack |-> (req_stb || req_end))
    else $error("req_ack without a live request strobe");

  a_rdy_sticky: assert property (@(posedge clk) disable iff (rst) rdy |=> rdy)
    else $error("rdy dropped without reset");

endmodule

bind dcm_ptc dcm_ptc_props u_props (
  .clk(clk), .rst(rst), .rdy(rdy),
  .req_stb(req_stb), .req_end(req_end), .req_ack(req_ack),
  .ptw_stb(ptw_stb), .ptw_eor(ptw_eor), .ptw_data(ptw_data),
  .pwf_clr(pwf_clr), .pwf_wen(pwf_wen)
);

//--- tb_dcm_ptc.sv
// ==========================================================
// directed testbench for the page table controller
// expected writes are queued in order and matched by a
// monitor on every ptw_stb; tid/rid slots must be distinct
// ==========================================================
`timescale 1ns/1ps

module tb_dcm_ptc
  import dcm_ptc_pkg::*;
();

  // sweep of 128 writes plus well under 600 test cycles
  localparam int max_cycles = 2000;
  localparam int rec_w = 4 + page_addr_w + pte_w;

  logic clk, rst, rdy;
  logic req_stb, req_end, req_ack, req_rdy;
  logic [rid_w-1:0] req_rid;
  logic req_tid, req_wid, req_tag;
  logic [page_addr_w-1:0] req_page;
  logic [vaddr_w-1:0] req_v_addr;
  logic ack_stb, ack_tid;
  logic [rid_w-1:0] ack_rid;
  logic ptw_stb, ptw_tid, ptw_eor, ptw_wid;
  logic [page_addr_w-1:0] ptw_page;
  logic [pte_w-1:0] ptw_data;
  logic pwf_clr, pwf_wen, pwf_tid, pwf_wid;
  logic [page_addr_w-1:0] pwf_page;

  // reference copy of the request buffer
  logic [page_addr_w-1:0] mdl_page [buf_depth];
  logic                   mdl_wid  [buf_depth];
  logic                   mdl_tag  [buf_depth];
  logic [vaddr_w-1:0]     mdl_va   [buf_depth];

  logic [rec_w-1:0] exp_q [$];
  logic [rec_w-1:0] act_w;
  logic [rec_w-1:0] act_f;
  logic [31:0] rng = 32'h54c8_818d;
  string cur_test;
  int cyc = 0;
  int rd_idx = 0;
  int wr_cnt = 0;
  int last_wr_cyc = 0;
  int prev_wr_cyc = 0;
  int sample_cyc = 0;
  int err_cnt = 0;
  int mon_err = 0;
  int test_err0 = 0;
  int n_tests = 0;
  int n_bad = 0;

  dcm_ptc u_dcm_ptc (.*);

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cyc <= cyc + 1;
    if (cyc >= max_cycles)
    begin
      $display("timeout, run stopped after %0d cycles", cyc);
      $display("Finished with errors");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // entry word layout, bit by bit
  function automatic logic [pte_w-1:0] pte_word(
    input logic done,
    input logic tag,
    input logic [vaddr_w-1:0] va
  );
    logic [pte_w-1:0] w;
    w = '0;
    if (done)
      w[31:11] = va[31:11];
    w[10] = done;
    w[9:8] = done ? 2'b10 : 2'b01;
    w[7] = tag;
    w[5:4] = {va[31], va[31]};
    w[3:0] = done ? 4'b1110 : 4'b0000;
    return w;
  endfunction

  function automatic logic [rec_w-1:0] make_rec(
    input logic clr,
    input logic tid,
    input logic eor,
    input logic wid,
    input logic [page_addr_w-1:0] page,
    input logic [pte_w-1:0] data
  );
    return {clr, tid, eor, wid, page, data};
  endfunction

  // ==========================================================
  // write monitor
  // ==========================================================

  always @(negedge clk)
  begin
    if (!rst && ptw_stb)
    begin
      wr_cnt = wr_cnt + 1;
      prev_wr_cyc = last_wr_cyc;
      last_wr_cyc = cyc;
      act_w = make_rec(pwf_clr, ptw_tid, ptw_eor, ptw_wid, ptw_page, ptw_data);
      // flag table port carries its own copy of the address
      act_f = make_rec(pwf_clr, pwf_tid, ptw_eor, pwf_wid, pwf_page, ptw_data);
      assert (rd_idx < exp_q.size())
      else
      begin
        $display("%s: page table write with none expected, record %h", cur_test, act_w);
        mon_err = mon_err + 1;
      end
      if (rd_idx < exp_q.size())
      begin
        assert (act_w == exp_q[rd_idx])
        else
        begin
          $display("FAILED %s: expected %h, actual %h", cur_test, exp_q[rd_idx], act_w);
          mon_err = mon_err + 1;
        end
        assert (act_f == exp_q[rd_idx])
        else
        begin
          $display("FAILED %s: expected %h, actual %h on the flag port", cur_test,
                   exp_q[rd_idx], act_f);
          mon_err = mon_err + 1;
        end
        rd_idx = rd_idx + 1;
      end
    end
  end

  // ==========================================================
  // helpers
  // ==========================================================

  task automatic open_test(input string name);
    cur_test = name;
    test_err0 = err_cnt + mon_err;
  endtask

  task automatic close_test();
    int n;
    n = err_cnt + mon_err - test_err0;
    n_tests++;
    if (n == 0)
      $display("test %s: passed", cur_test);
    else
    begin
      n_bad++;
      $display("test %s: failed, %0d errors", cur_test, n);
    end
  endtask

  // monitor updates on negedge, so look on posedge
  task automatic wait_drained();
    int n;
    n = 0;
    while (rd_idx < exp_q.size() && n < 50)
    begin
      @(posedge clk);
      n++;
    end
    assert (rd_idx == exp_q.size())
    else
    begin
      $display("%s: %0d expected writes never appeared", cur_test, exp_q.size() - rd_idx);
      err_cnt++;
    end
  endtask

  // start or end request, held until req_ack
  task automatic send_req(
    input logic is_end,
    input logic tid,
    input logic [rid_w-1:0] rid,
    input logic wid
  );
    logic [vaddr_w-1:0] va;
    logic [31:0] r;
    int n;
    va = xorshift32();
    r = xorshift32();
    if (!is_end)
    begin
      mdl_page[{tid, rid}] = r[4:0];
      mdl_wid[{tid, rid}] = wid;
      mdl_tag[{tid, rid}] = r[8];
      mdl_va[{tid, rid}] = va;
    end
    exp_q.push_back(make_rec(1'b0, tid, 1'b0, wid, r[4:0], pte_word(is_end, r[8], va)));
    @(posedge clk);
    req_stb <= !is_end;
    req_end <= is_end;
    req_tid <= tid;
    req_rid <= rid;
    req_wid <= wid;
    req_tag <= r[8];
    req_page <= r[4:0];
    req_v_addr <= va;
    n = 0;
    do
    begin
      @(negedge clk);
      n++;
    end
    while (!req_ack && n < 20);
    sample_cyc = cyc;
    assert (req_ack)
    else
    begin
      $display("%s: no req_ack within 20 cycles", cur_test);
      err_cnt++;
    end
    assert (!req_rdy)
    else
    begin
      $display("%s: req_rdy high while a request is held", cur_test);
      err_cnt++;
    end
    @(posedge clk);
    req_stb <= 1'b0;
    req_end <= 1'b0;
    @(negedge clk);
    assert (req_rdy)
    else
    begin
      $display("%s: req_rdy did not return after release", cur_test);
      err_cnt++;
    end
  endtask

  // one ack cycle, completes the buffered slot
  task automatic send_ack(input logic tid, input logic [rid_w-1:0] rid);
    logic [rid_w:0] i;
    i = {tid, rid};
    exp_q.push_back(make_rec(1'b0, tid, 1'b1, mdl_wid[i], mdl_page[i],
                             pte_word(1'b1, mdl_tag[i], mdl_va[i])));
    @(posedge clk);
    ack_stb <= 1'b1;
    ack_tid <= tid;
    ack_rid <= rid;
  endtask

  // ==========================================================
  // tests
  // ==========================================================

  task automatic test_reset_sweep();
    logic [6:0] k;
    int n;
    open_test("reset_sweep");
    for (int i = 0; i < 128; i++)
    begin
      k = 7'(i);
      exp_q.push_back(make_rec(1'b1, k[6], 1'b0, k[5], k[4:0], '0));
    end
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    assert (!rdy)
    else
    begin
      $display("%s: rdy high right after reset", cur_test);
      err_cnt++;
    end
    n = 0;
    while (!rdy && n < 200)
    begin
      @(negedge clk);
      n++;
    end
    assert (rdy)
    else
    begin
      $display("%s: rdy never rose after the sweep", cur_test);
      err_cnt++;
    end
    wait_drained();
    // any stray write is flagged by the monitor
    repeat (10) @(posedge clk);
    assert (wr_cnt == 128)
    else
    begin
      $display("FAILED %s: expected %0d, actual %0d", cur_test, 128, wr_cnt);
      err_cnt++;
    end
    close_test();
  endtask

  task automatic test_start_req();
    open_test("start_req");
    send_req(1'b0, 1'b1, 4'd2, 1'b1);
    wait_drained();
    assert (last_wr_cyc == sample_cyc + 3)
    else
    begin
      $display("FAILED %s: expected %0d, actual %0d", cur_test, sample_cyc + 3, last_wr_cyc);
      err_cnt++;
    end
    close_test();
  endtask

  task automatic test_end_req();
    open_test("end_req");
    send_req(1'b1, 1'b0, 4'd0, 1'b1);
    send_req(1'b1, 1'b1, 4'd7, 1'b0);
    wait_drained();
    close_test();
  endtask

  task automatic test_ack_complete();
    open_test("ack_complete");
    send_req(1'b0, 1'b0, 4'd3, 1'b1);
    send_req(1'b0, 1'b1, 4'd3, 1'b0);
    send_req(1'b0, 1'b0, 4'd9, 1'b0);
    send_req(1'b0, 1'b1, 4'd14, 1'b1);
    wait_drained();
    send_ack(1'b0, 4'd9);
    send_ack(1'b1, 4'd3);
    send_ack(1'b1, 4'd14);
    send_ack(1'b0, 4'd3);
    @(posedge clk);
    ack_stb <= 1'b0;
    wait_drained();
    close_test();
  endtask

  // ack on the edge after the capture wins the entry generator
  task automatic test_ack_priority();
    logic [vaddr_w-1:0] va;
    logic [31:0] r;
    open_test("ack_priority");
    va = xorshift32();
    r = xorshift32();
    exp_q.push_back(make_rec(1'b0, 1'b1, 1'b1, mdl_wid[5'd30], mdl_page[5'd30],
                             pte_word(1'b1, mdl_tag[5'd30], mdl_va[5'd30])));
    exp_q.push_back(make_rec(1'b0, 1'b0, 1'b0, 1'b1, r[4:0], pte_word(1'b0, r[8], va)));
    @(posedge clk);
    req_stb <= 1'b1;
    req_tid <= 1'b0;
    req_rid <= 4'd5;
    req_wid <= 1'b1;
    req_tag <= r[8];
    req_page <= r[4:0];
    req_v_addr <= va;
    @(posedge clk);
    ack_stb <= 1'b1;
    ack_tid <= 1'b1;
    ack_rid <= 4'd14;
    @(negedge clk);
    sample_cyc = cyc;
    assert (req_ack && !req_rdy)
    else
    begin
      $display("%s: start not held with req_ack high", cur_test);
      err_cnt++;
    end
    @(posedge clk);
    ack_stb <= 1'b0;
    req_stb <= 1'b0;
    @(negedge clk);
    assert (!req_rdy)
    else
    begin
      $display("%s: req_rdy rose while the ack held the stage", cur_test);
      err_cnt++;
    end
    @(negedge clk);
    assert (req_rdy)
    else
    begin
      $display("%s: req_rdy did not return after the ack", cur_test);
      err_cnt++;
    end
    wait_drained();
    assert (prev_wr_cyc == sample_cyc + 3)
    else
    begin
      $display("FAILED %s: expected %0d, actual %0d", cur_test,
               sample_cyc + 3, prev_wr_cyc);
      err_cnt++;
    end
    assert (last_wr_cyc == sample_cyc + 4)
    else
    begin
      $display("FAILED %s: expected %0d, actual %0d", cur_test,
               sample_cyc + 4, last_wr_cyc);
      err_cnt++;
    end
    close_test();
  endtask

  initial
  begin
    rst = 1'b1;
    req_stb = 1'b0;
    req_end = 1'b0;
    req_rid = '0;
    req_tid = 1'b0;
    req_wid = 1'b0;
    req_tag = 1'b0;
    req_page = '0;
    req_v_addr = '0;
    ack_stb = 1'b0;
    ack_rid = '0;
    ack_tid = 1'b0;
    test_reset_sweep();
    test_start_req();
    test_end_req();
    test_ack_complete();
    test_ack_priority();
    $display("tests run %0d, tests failed %0d, errors %0d", n_tests, n_bad, err_cnt + mon_err);
    if (err_cnt + mon_err == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

//--- project.f
dcm_ptc_pkg.sv
dcm_ptc_if.sv
ptc_req_stage.sv
ptc_req_buffer.sv
ptc_entry_gen.sv
ptc_out_pipe.sv
dcm_ptc.sv
dcm_ptc_props.sv
tb_dcm_ptc.sv

//--- run.sh
#!/bin/sh
# build and run the page table controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing -f project.f --top-module tb_dcm_ptc -o sim_dcm_ptc

if ! ./obj_dir/sim_dcm_ptc > sim.log 2>&1; then
  cat sim.log
  echo "simulation exited with an error status"
  exit 1
fi
cat sim.log

if grep -q "Finished with errors" sim.log; then
  exit 1
fi
if ! grep -q "Finished with no errors" sim.log; then
  echo "simulation ended without a result line"
  exit 1
fi
